//--- exec_core.f
src/exec_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/exec_int.sv
src/exec_branch.sv
src/exec_stage.sv
src/exec_core.sv
verification/tb_exec_core.sv

//--- verification/tb_exec_core.sv
`default_nettype none

module tb_exec_core;
    import exec_pkg::*;

    localparam int          RAND_COUNT      = 200;
    localparam int          DIRECTED_COUNT  = 80;
    localparam int          WATCHDOG_CYCLES = 20 * (RAND_COUNT + DIRECTED_COUNT) + 100;
    localparam logic [31:0] SEED            = 32'he7c0_7901;

    // One entry per strobed instruction, all flags low when it is squashed
    typedef struct packed {
        logic        ret;
        logic        trap;
        logic        redir;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] addr;
        logic [3:0]  cause;
        logic [31:0] target;
        logic [31:0] due;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_addr;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic [31:0] retire_addr;
    logic        trap_valid;
    logic [3:0]  trap_cause;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    logic [31:0] mregs [32];            // Architectural register model
    expect_t     exp_q [$];
    expect_t     head;
    int          cycle = 0;
    int          flush_cycle = -10;     // Cycle whose strobe lands on the wrong path
    logic [31:0] cur_pc = 32'h0000_1000;
    int unsigned seed_ret;

    exec_core i_dut (
        .clk, .rst, .instr_valid, .instr, .instr_addr,
        .retire_valid, .retire_rd, .retire_data, .retire_addr,
        .trap_valid, .trap_cause, .redirect_valid, .redirect_pc
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] enc_r(input logic [4:0] opc, input logic [2:0] f3,
                                          input logic alt, input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_i(input logic [4:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_u(input logic [4:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                          input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH, 2'b11};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL, 2'b11};
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $unsigned($signed(a) >>> b[4:0]);
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Expected outputs of one instruction from the RV32I rules
    function automatic expect_t predict(input logic [31:0] ins, input logic [31:0] pc);
        expect_t     e;
        logic [2:0]  f3;
        logic [31:0] a, b, imm_i, imm_b, imm_u, imm_j, tgt;
        logic        legal, ctrl, taken;
        e     = '0;
        f3    = ins[14:12];
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        e.rd   = ins[11:7];
        e.addr = pc;
        legal  = ins[1:0] == 2'b11;
        ctrl   = 1'b0;
        taken  = 1'b0;
        tgt    = '0;
        case (ins[6:2])
            OPC_LUI:    e.data = imm_u;
            OPC_AUIPC:  e.data = pc + imm_u;
            OPC_OP:     e.data = alu(f3, ins[30], a, b);
            OPC_OP_IMM: e.data = alu(f3, ins[30] && f3 == 3'd5, a, imm_i);
            OPC_JAL: begin
                ctrl  = 1'b1;
                taken = 1'b1;
                tgt   = pc + imm_j;
            end
            OPC_JALR: begin
                ctrl  = 1'b1;
                taken = 1'b1;
                tgt   = (a + imm_i) & 32'hFFFF_FFFE;
            end
            OPC_BRANCH: begin
                ctrl  = 1'b1;
                e.rd  = 5'd0;           // No link register
                taken = branch_taken(f3, a, b);
                tgt   = pc + imm_b;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            e.trap  = 1'b1;
            e.cause = CAUSE_ILLEGAL;
        end else if (taken && tgt[1]) begin
            e.trap  = 1'b1;
            e.cause = CAUSE_MISALIGNED;
        end else begin
            e.ret    = 1'b1;
            e.redir  = taken;
            e.target = tgt;
            if (ctrl) begin
                e.data = pc + 32'd4;
            end
        end
        return e;
    endfunction

    task automatic report_fail(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "Output check did not hold");
    endtask

    task automatic issue(input logic [31:0] ins);
        expect_t e;
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = ins;
        instr_addr  = cur_pc;
        if (cycle == flush_cycle) begin
            e = '0;                     // Squashed by the flush
        end else begin
            e = predict(ins, cur_pc);
            if (e.ret && e.rd != 5'd0) begin
                mregs[e.rd] = e.data;
            end
            if (e.trap || e.redir) begin
                flush_cycle = cycle + 1;
            end
            cur_pc = e.redir ? e.target : cur_pc + 32'd4;
        end
        e.due = 32'(cycle + 2);
        exp_q.push_back(e);
    endtask

    task automatic gap(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain();
        gap(1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (exp_q.size() != 0 && exp_q[0].due == 32'(cycle)) begin
                head = exp_q.pop_front();
                assert (retire_valid == head.ret && trap_valid == head.trap &&
                        redirect_valid == head.redir)
                else report_fail($sformatf("strobes rtd %b%b%b, expected %b%b%b, pc %h",
                    retire_valid, trap_valid, redirect_valid,
                    head.ret, head.trap, head.redir, head.addr));
                if (head.ret) begin
                    assert (retire_rd == head.rd && retire_addr == head.addr)
                    else report_fail($sformatf("retire rd/addr %0d/%h, expected %0d/%h",
                        retire_rd, retire_addr, head.rd, head.addr));
                    assert (retire_data == head.data)
                    else report_fail($sformatf("retire_data %h, expected %h, pc %h",
                        retire_data, head.data, head.addr));
                end
                if (head.trap) begin
                    assert (trap_cause == head.cause)
                    else report_fail($sformatf("trap_cause %0d, expected %0d",
                        trap_cause, head.cause));
                end
                if (head.redir) begin
                    assert (redirect_pc == head.target)
                    else report_fail($sformatf("redirect_pc %h, expected %h",
                        redirect_pc, head.target));
                end
            end else begin
                assert (!(retire_valid || trap_valid || redirect_valid))
                else report_fail("output strobe with no instruction due");
            end
        end
    end

    task automatic test_alu();
        logic [31:0] r;
        logic [2:0]  f3;
        r = $urandom;
        issue(enc_u(OPC_LUI, 5'd1, r[31:12]));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd1, 5'd1, r[11:0]));
        r = $urandom;
        issue(enc_u(OPC_LUI, 5'd2, r[31:12]));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd2, 5'd2, r[11:0]));
        for (int f = 0; f < 10; f++) begin  // Last two are SUB and SRA
            f3 = (f < 8) ? 3'(f) : ((f == 8) ? 3'd0 : 3'd5);
            issue(enc_r(OPC_OP, f3, f >= 8, 5'(f + 3), 5'(f + 2), 5'(f + 1)));
        end
        for (int f = 0; f < 9; f++) begin
            r  = $urandom;
            f3 = (f < 8) ? 3'(f) : 3'd5;
            if (f3 == 3'd1 || f3 == 3'd5) begin
                r[11:5] = (f == 8) ? 7'h20 : 7'h00;
            end
            issue(enc_i(OPC_OP_IMM, f3, 5'(f + 13), 5'(f + 12), r[11:0]));
        end
        issue(enc_u(OPC_AUIPC, 5'd22, r[31:12]));
        drain();
    endtask

    task automatic test_x0();
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd0, 5'd1, 12'h123));
        issue(enc_r(OPC_OP, 3'd0, 1'b0, 5'd23, 5'd0, 5'd0));
        issue(enc_u(OPC_LUI, 5'd0, 20'hABCDE));
        gap(2);
        issue(enc_i(OPC_OP_IMM, 3'd6, 5'd24, 5'd0, 12'h000));
        drain();
    endtask

    task automatic test_branch();
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'd5));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'd5));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd3, 5'd0, 12'hFFD)); // -3
        issue(enc_b(3'd0, 5'd1, 5'd2, 13'd16));               // BEQ taken
        issue(enc_r(OPC_OP, 3'd0, 1'b0, 5'd4, 5'd1, 5'd2));   // Wrong path
        issue(enc_r(OPC_OP, 3'd0, 1'b0, 5'd4, 5'd1, 5'd2));
        issue(enc_b(3'd1, 5'd1, 5'd2, 13'd8));                // BNE not taken
        issue(enc_r(OPC_OP, 3'd0, 1'b1, 5'd5, 5'd4, 5'd3));
        issue(enc_b(3'd4, 5'd3, 5'd1, 13'h1FF8));             // BLT backward
        issue(enc_r(OPC_OP, 3'd4, 1'b0, 5'd5, 5'd5, 5'd1));
        gap(1);
        issue(enc_b(3'd6, 5'd3, 5'd1, 13'd12));               // BLTU not taken
        issue(enc_b(3'd5, 5'd1, 5'd3, 13'd20));               // BGE taken
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd8, 5'd0, 12'd9));
        issue(enc_j(5'd6, 21'd64));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd8, 5'd0, 12'd9));
        issue(enc_i(OPC_JALR, 3'd0, 5'd7, 5'd6, 12'd12));     // Link through write-through
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd8, 5'd0, 12'd9));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd8, 5'd7, 12'd1));
        issue(enc_b(3'd7, 5'd1, 5'd3, 13'd8));                // BGEU not taken
        drain();
    endtask

    task automatic test_illegal();
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd5, 5'd0, 12'h055));
        issue(enc_i(5'b00000, 3'd2, 5'd5, 5'd0, 12'h000));    // Load opcode
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd5, 5'd0, 12'h011));
        issue(enc_r(OPC_OP, 3'd0, 1'b0, 5'd9, 5'd5, 5'd0));
        issue(32'hFFFF_FFFF);
        gap(2);
        issue(32'h0000_0000);
        gap(1);
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd5, 5'd0, 12'h077) & 32'hFFFF_FFFD);
        issue(enc_r(OPC_OP, 3'd0, 1'b0, 5'd9, 5'd5, 5'd0));
        drain();
    endtask

    task automatic test_misaligned();
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd7, 5'd0, 12'h102));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd8, 5'd0, 12'h101));
        gap(1);
        issue(enc_i(OPC_JALR, 3'd0, 5'd1, 5'd7, 12'd0));      // Target bit 1 set
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd9, 5'd0, 12'd1));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd9, 5'd0, 12'd2));
        issue(enc_i(OPC_JALR, 3'd0, 5'd1, 5'd8, 12'd0));      // Bit 0 cleared only
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd9, 5'd0, 12'd3));
        issue(enc_b(3'd0, 5'd0, 5'd0, 13'd6));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd9, 5'd0, 12'd4));
        issue(enc_j(5'd1, 21'd2));
        issue(enc_i(OPC_OP_IMM, 3'd0, 5'd9, 5'd0, 12'd5));
        drain();
    endtask

    task automatic test_random(input int count);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        int          kind;
        for (int n = 0; n < count; n++) begin
            r    = $urandom;
            kind = int'($urandom % 10);
            rd   = 5'($urandom % 8);
            rs1  = 5'($urandom % 8);
            rs2  = 5'($urandom % 8);
            f3   = r[14:12];
            case (kind)
                0, 1, 2: issue(enc_r(OPC_OP, f3, r[30] && (f3 == 3'd0 || f3 == 3'd5),
                                     rd, rs1, rs2));
                3, 4, 5: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        r[31:25] = {1'b0, r[30] && f3 == 3'd5, 5'b0};
                    end
                    issue(enc_i(OPC_OP_IMM, f3, rd, rs1, r[31:20]));
                end
                6: issue(enc_u(OPC_LUI, rd, r[31:12]));
                7: begin
                    f3 = r[2:0];
                    if (f3 == 3'd2 || f3 == 3'd3) begin
                        f3 = 3'd0;
                    end
                    issue(enc_b(f3, rs1, rs2, {{5{r[20]}}, r[5:0], 2'b00}));
                end
                8: issue(enc_j(rd, {{13{r[20]}}, r[5:0], 2'b00}));
                default: issue(enc_i(OPC_JALR, 3'd0, rd, rs1, r[31:20]));
            endcase
            if (r[7]) begin
                gap(int'(r[9:8]));
            end
        end
        drain();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        seed_ret    = $urandom(SEED);
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_addr  = '0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_alu();
        test_x0();
        test_branch();
        test_illegal();
        test_misaligned();
        test_random(RAND_COUNT);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/exec_core.sv
`default_nettype none

module exec_core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  logic [exec_pkg::ILEN-1:0]   instr,
    input  logic [exec_pkg::XLEN-1:0]   instr_addr,
    output logic                        retire_valid,
    output logic [exec_pkg::RSEL_W-1:0] retire_rd,
    output logic [exec_pkg::XLEN-1:0]   retire_data,
    output logic [exec_pkg::XLEN-1:0]   retire_addr,
    output logic                        trap_valid,
    output logic [3:0]                  trap_cause,
    output logic                        redirect_valid,
    output logic [exec_pkg::XLEN-1:0]   redirect_pc
);
    import exec_pkg::*;

    logic [RSEL_W-1:0] rs1_sel, rs2_sel;
    logic [XLEN-1:0]   rs1_data, rs2_data;
    logic              flush;
    logic              dec_valid, dec_illegal, dec_funct7_bit;
    unit_e             dec_unit;
    logic [2:0]        dec_funct3;
    logic [RSEL_W-1:0] dec_rd, dec_rs1, dec_rs2;
    logic [XLEN-1:0]   dec_rs1_data, dec_rs2_data, dec_imm, dec_pc;
    logic              dec_use_imm, dec_is_upper, dec_upper_pc;

    decode_stage i_decode (
        .clk, .rst, .instr_valid, .instr, .instr_addr, .flush,
        .rs1_sel, .rs2_sel, .rs1_data, .rs2_data,
        .dec_valid, .dec_unit, .dec_illegal, .dec_funct3, .dec_funct7_bit,
        .dec_rd, .dec_rs1, .dec_rs2, .dec_rs1_data, .dec_rs2_data,
        .dec_imm, .dec_use_imm, .dec_pc, .dec_is_upper, .dec_upper_pc
    );

    reg_file i_regs (
        .clk, .rst, .rs1_sel, .rs2_sel, .rs1_data, .rs2_data,
        .we     (retire_valid), // Retire port is the only writer
        .wd_sel (retire_rd),
        .wd     (retire_data)
    );

    exec_stage i_exec (
        .clk, .rst,
        .dec_valid, .dec_unit, .dec_illegal, .dec_funct3, .dec_funct7_bit,
        .dec_rd, .dec_rs1, .dec_rs2, .dec_rs1_data, .dec_rs2_data,
        .dec_imm, .dec_use_imm, .dec_pc, .dec_is_upper, .dec_upper_pc,
        .flush, .retire_valid, .retire_rd, .retire_data, .retire_addr,
        .trap_valid, .trap_cause, .redirect_valid, .redirect_pc
    );

endmodule

`default_nettype wire

//--- src/exec_stage.sv
`default_nettype none

module exec_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dec_valid,
    input  exec_pkg::unit_e             dec_unit,
    input  logic                        dec_illegal,
    input  logic [2:0]                  dec_funct3,
    input  logic                        dec_funct7_bit,
    input  logic [exec_pkg::RSEL_W-1:0] dec_rd,
    input  logic [exec_pkg::RSEL_W-1:0] dec_rs1,
    input  logic [exec_pkg::RSEL_W-1:0] dec_rs2,
    input  logic [exec_pkg::XLEN-1:0]   dec_rs1_data,
    input  logic [exec_pkg::XLEN-1:0]   dec_rs2_data,
    input  logic [exec_pkg::XLEN-1:0]   dec_imm,
    input  logic                        dec_use_imm,
    input  logic [exec_pkg::XLEN-1:0]   dec_pc,
    input  logic                        dec_is_upper,
    input  logic                        dec_upper_pc,
    output logic                        flush,
    output logic                        retire_valid,
    output logic [exec_pkg::RSEL_W-1:0] retire_rd,
    output logic [exec_pkg::XLEN-1:0]   retire_data,
    output logic [exec_pkg::XLEN-1:0]   retire_addr,
    output logic                        trap_valid,
    output logic [3:0]                  trap_cause,
    output logic                        redirect_valid,
    output logic [exec_pkg::XLEN-1:0]   redirect_pc
);
    import exec_pkg::*;

    logic [XLEN-1:0] op_a, op_b, int_result, br_target, br_link;
    logic            is_branch, is_jal, is_jalr;
    logic            br_taken, br_misaligned, trap_now;

    // Previous result is not yet in the register file
    assign op_a = (retire_valid && retire_rd != '0 && retire_rd == dec_rs1) ?
                  retire_data : dec_rs1_data;
    assign op_b = (retire_valid && retire_rd != '0 && retire_rd == dec_rs2) ?
                  retire_data : dec_rs2_data;

    assign is_branch = dec_unit == UNIT_BRANCH;
    assign is_jal    = is_branch && dec_use_imm && dec_upper_pc;
    assign is_jalr   = is_branch && dec_use_imm && !dec_upper_pc;

    exec_int i_int (
        .funct3     (dec_funct3),
        .funct7_bit (dec_funct7_bit),
        .use_imm    (dec_use_imm),
        .is_upper   (dec_is_upper),
        .upper_pc   (dec_upper_pc),
        .op_a       (op_a),
        .op_b       (op_b),
        .imm        (dec_imm),
        .pc         (dec_pc),
        .result     (int_result)
    );

    exec_branch i_branch (
        .funct3     (dec_funct3),
        .is_jal     (is_jal),
        .is_jalr    (is_jalr),
        .op_a       (op_a),
        .op_b       (op_b),
        .imm        (dec_imm),
        .pc         (dec_pc),
        .taken      (br_taken),
        .target     (br_target),
        .link       (br_link),
        .misaligned (br_misaligned)
    );

    assign trap_now = dec_illegal || (is_branch && br_misaligned);

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid   <= 1'b0;
            trap_valid     <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            retire_valid   <= dec_valid && !trap_now;
            trap_valid     <= dec_valid && trap_now;
            redirect_valid <= dec_valid && !trap_now && is_branch && br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            retire_rd   <= dec_rd;
            retire_data <= is_branch ? br_link : int_result;
            retire_addr <= dec_pc;
            trap_cause  <= dec_illegal ? CAUSE_ILLEGAL : CAUSE_MISALIGNED;
            redirect_pc <= br_target;
        end
    end

    assign flush = trap_valid || redirect_valid;

    a_trap_not_retire: assert property (
        @(posedge clk) disable iff (rst) !(trap_valid && retire_valid));

    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (rst) redirect_valid |-> redirect_pc[1:0] == 2'b00);

    // Wrong-path item in decode must be squashed
    a_flush_kills_next: assert property (
        @(posedge clk) disable iff (rst)
        flush |=> !(retire_valid || trap_valid || redirect_valid));

endmodule

`default_nettype wire

//--- src/exec_branch.sv
`default_nettype none

module exec_branch (
    input  logic [2:0]                funct3,
    input  logic                      is_jal,
    input  logic                      is_jalr,
    input  logic [exec_pkg::XLEN-1:0] op_a,
    input  logic [exec_pkg::XLEN-1:0] op_b,
    input  logic [exec_pkg::XLEN-1:0] imm,
    input  logic [exec_pkg::XLEN-1:0] pc,
    output logic                      taken,
    output logic [exec_pkg::XLEN-1:0] target,
    output logic [exec_pkg::XLEN-1:0] link,
    output logic                      misaligned
);
    import exec_pkg::*;

    logic            cond;
    logic [XLEN-1:0] sum;

    always_comb begin
        case (funct3)
            F3_BEQ:  cond = op_a == op_b;
            F3_BNE:  cond = op_a != op_b;
            F3_BLT:  cond = $signed(op_a) < $signed(op_b);
            F3_BGE:  cond = $signed(op_a) >= $signed(op_b);
            F3_BLTU: cond = op_a < op_b;
            F3_BGEU: cond = op_a >= op_b;
            default: cond = 1'b0;
        endcase
    end

    assign sum    = (is_jalr ? op_a : pc) + imm;
    assign target = is_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

    assign taken      = is_jal || is_jalr || cond;
    assign link       = pc + 32'd4;
    assign misaligned = taken && target[1]; // No compressed support
endmodule

`default_nettype wire

//--- src/exec_int.sv
`default_nettype none

module exec_int (
    input  logic [2:0]                funct3,
    input  logic                      funct7_bit,
    input  logic                      use_imm,
    input  logic                      is_upper,
    input  logic                      upper_pc,
    input  logic [exec_pkg::XLEN-1:0] op_a,
    input  logic [exec_pkg::XLEN-1:0] op_b,
    input  logic [exec_pkg::XLEN-1:0] imm,
    input  logic [exec_pkg::XLEN-1:0] pc,
    output logic [exec_pkg::XLEN-1:0] result
);
    import exec_pkg::*;

    logic [XLEN-1:0] b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu;

    assign b     = use_imm ? imm : op_b;
    assign shamt = b[4:0];

    always_comb begin
        case (funct3)
            F3_ADD: begin
                if (funct7_bit && !use_imm) begin // ADDI has no subtract form
                    alu = op_a - b;
                end else begin
                    alu = op_a + b;
                end
            end
            F3_SLL:  alu = op_a << shamt;
            F3_SLT:  alu = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(b)};
            F3_SLTU: alu = {{(XLEN-1){1'b0}}, op_a < b};
            F3_XOR:  alu = op_a ^ b;
            F3_SR: begin
                if (funct7_bit) begin
                    alu = $unsigned($signed(op_a) >>> shamt);
                end else begin
                    alu = op_a >> shamt;
                end
            end
            F3_OR:   alu = op_a | b;
            F3_AND:  alu = op_a & b;
            default: alu = '0;
        endcase
    end

    always_comb begin
        if (is_upper) begin
            result = upper_pc ? pc + imm : imm; // AUIPC or LUI
        end else begin
            result = alu;
        end
    end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  logic [exec_pkg::ILEN-1:0]   instr,
    input  logic [exec_pkg::XLEN-1:0]   instr_addr,
    input  logic                        flush,
    output logic [exec_pkg::RSEL_W-1:0] rs1_sel,
    output logic [exec_pkg::RSEL_W-1:0] rs2_sel,
    input  logic [exec_pkg::XLEN-1:0]   rs1_data,
    input  logic [exec_pkg::XLEN-1:0]   rs2_data,
    output logic                        dec_valid,
    output exec_pkg::unit_e             dec_unit,
    output logic                        dec_illegal,
    output logic [2:0]                  dec_funct3,
    output logic                        dec_funct7_bit,
    output logic [exec_pkg::RSEL_W-1:0] dec_rd,
    output logic [exec_pkg::RSEL_W-1:0] dec_rs1,
    output logic [exec_pkg::RSEL_W-1:0] dec_rs2,
    output logic [exec_pkg::XLEN-1:0]   dec_rs1_data,
    output logic [exec_pkg::XLEN-1:0]   dec_rs2_data,
    output logic [exec_pkg::XLEN-1:0]   dec_imm,
    output logic                        dec_use_imm,
    output logic [exec_pkg::XLEN-1:0]   dec_pc,
    output logic                        dec_is_upper,
    output logic                        dec_upper_pc
);
    import exec_pkg::*;

    logic [4:0]      opcode;
    logic [XLEN-1:0] i_imm, b_imm, u_imm, j_imm;
    unit_e           unit;
    logic            illegal, use_imm, is_upper, upper_pc, keeps_rd;
    logic [XLEN-1:0] imm;
    logic            held_valid;

    assign opcode  = instr[6:2];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // For the branch unit, use_imm marks a jump and upper_pc a PC-relative target
    always_comb begin
        unit     = UNIT_NONE;
        illegal  = 1'b0;
        imm      = i_imm;
        use_imm  = 1'b0;
        is_upper = 1'b0;
        upper_pc = 1'b0;
        keeps_rd = 1'b1;
        case (opcode)
            OPC_OP:     unit = UNIT_INT;
            OPC_OP_IMM: begin
                unit    = UNIT_INT;
                use_imm = 1'b1;
            end
            OPC_LUI: begin
                unit     = UNIT_INT;
                is_upper = 1'b1;
                imm      = u_imm;
            end
            OPC_AUIPC: begin
                unit     = UNIT_INT;
                is_upper = 1'b1;
                upper_pc = 1'b1;
                imm      = u_imm;
            end
            OPC_JAL: begin
                unit     = UNIT_BRANCH;
                use_imm  = 1'b1;
                upper_pc = 1'b1;
                imm      = j_imm;
            end
            OPC_JALR: begin
                unit    = UNIT_BRANCH;
                use_imm = 1'b1;
            end
            OPC_BRANCH: begin
                unit     = UNIT_BRANCH;
                imm      = b_imm;
                keeps_rd = 1'b0; // rd field holds immediate bits
            end
            default: illegal = 1'b1;
        endcase
        if (instr[1:0] != 2'b11) begin // Compressed or reserved encoding
            unit    = UNIT_NONE;
            illegal = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else begin
            held_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_unit       <= unit;
            dec_illegal    <= illegal;
            dec_funct3     <= instr[14:12];
            dec_funct7_bit <= instr[30];
            dec_rd         <= keeps_rd ? instr[11:7] : '0;
            dec_rs1        <= rs1_sel;
            dec_rs2        <= rs2_sel;
            dec_rs1_data   <= rs1_data;
            dec_rs2_data   <= rs2_data;
            dec_imm        <= imm;
            dec_use_imm    <= use_imm;
            dec_pc         <= instr_addr;
            dec_is_upper   <= is_upper;
            dec_upper_pc   <= upper_pc;
        end
    end

    // Held item is wrong-path while execute shows a redirect or trap
    assign dec_valid = held_valid && !flush;

endmodule

`default_nettype wire

//--- src/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [exec_pkg::RSEL_W-1:0] rs1_sel,
    input  logic [exec_pkg::RSEL_W-1:0] rs2_sel,
    output logic [exec_pkg::XLEN-1:0]   rs1_data,
    output logic [exec_pkg::XLEN-1:0]   rs2_data,
    input  logic                        we,
    input  logic [exec_pkg::RSEL_W-1:0] wd_sel,
    input  logic [exec_pkg::XLEN-1:0]   wd
);
    import exec_pkg::*;

    logic [XLEN-1:0] regs [31:1]; // x0 has no storage

    function automatic logic [XLEN-1:0] read_port(input logic [RSEL_W-1:0] sel);
        if (sel == '0) begin
            return '0;
        end
        if (we && wd_sel == sel) begin
            return wd; // Same-cycle write wins
        end
        return regs[sel];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_sel != '0) begin
            regs[wd_sel] <= wd;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_sel);
        rs2_data = read_port(rs2_sel);
    end

endmodule

`default_nettype wire

//--- src/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN   = 32;
    localparam int ILEN   = 32;
    localparam int RSEL_W = 5;

    // Major opcodes, instr[6:2]
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;

    // ALU operations by funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch conditions by funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [3:0] CAUSE_MISALIGNED = 4'd0;
    localparam logic [3:0] CAUSE_ILLEGAL    = 4'd2;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_INT,
        UNIT_BRANCH
    } unit_e;

endpackage

`default_nettype wire
